/* verification/ahb_bram_trace.txt */
# kind(R W I) addr size burst wdata exp_rdata mode exp_hresp, all numbers hex except size burst mode
# mode 0 literal exp_rdata, 1 taken from the reference copy, 2 read data not checked
# lane updates then reads with zero extension
W 00000040 2 0 11223344 00000000 0 0
I 00000000 0 0 00000000 00000000 0 0
W 00000046 1 0 aabb0000 00000000 0 0
W 00000049 0 0 0000cc00 00000000 0 0
I 00000000 0 0 00000000 00000000 0 0
R 00000040 2 0 00000000 11223344 0 0
R 00000046 1 0 00000000 0000aabb 0 0
R 00000044 2 0 00000000 00000000 1 0
R 00000049 0 0 00000000 000000cc 0 0
R 00000042 0 0 00000000 00000022 0 0
# write then read of the same word, merged bytes, then drained
W 00000080 1 0 0000beef 00000000 0 0
R 00000080 2 0 00000000 00000000 1 0
I 00000000 0 0 00000000 00000000 0 0
R 00000080 1 0 00000000 0000beef 0 0
W 00000087 0 0 5a000000 00000000 0 0
R 00000085 0 0 00000000 00000000 1 0
R 00000087 0 0 00000000 0000005a 0 0
I 00000000 0 0 00000000 00000000 0 0
# other word reads old data, chained collisions drain through write after read
W 000000c0 2 0 cafef00d 00000000 0 0
R 000000d0 2 0 00000000 00000000 1 0
W 000000c4 2 0 a5a5a5a5 00000000 0 0
R 000000c0 2 0 00000000 cafef00d 0 0
R 000000c4 2 0 00000000 a5a5a5a5 0 0
I 00000000 0 0 00000000 00000000 0 0
R 000000c4 2 0 00000000 a5a5a5a5 0 0
# error responses, the transfer still runs
R 00000040 3 0 00000000 00000000 0 1
R 00000040 2 1 00000000 11223344 0 1
R 00000041 1 0 00000000 00000000 2 1
R 00000042 2 0 00000000 00000000 2 1
R 00000042 1 0 00000000 00001122 0 0
W 00000140 2 3 deadbeef 00000000 0 1
I 00000000 0 0 00000000 00000000 0 0
R 00000140 2 0 00000000 deadbeef 0 0

/* src.f */
verilog/ahb_bram_pkg.sv
verilog/ahb_bram_ifs.sv
verilog/ahb_bram_phase_fsm.sv
verilog/ahb_bram_resp_gen.sv
verilog/ahb_bram_write_buffer.sv
verilog/ahb_bram_port_mux.sv
verilog/ahb_bram_rdata_align.sv
verilog/ahb_bram_ctrl.sv
verification/ahb_bram_assert.sv
verification/tb_ahb_bram.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ahb_bram
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/tb_ahb_bram.sv */
// testbench for the AHB-Lite block RAM slave, replays the transfer trace against a RAM model
`timescale 1ns/1ps

module tb_ahb_bram import ahb_bram_pkg::*; ();

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int MEM_WORDS  = 256;
    localparam int MARGIN     = 20;
    localparam logic [31:0] SEED = 32'd89312;

    logic        HCLK;
    logic        HRESETn;
    logic        hsel;
    logic [31:0] haddr;
    logic        hwrite;
    hsize_e      hsize;
    logic [2:0]  hburst;
    htrans_e     htrans;
    logic        hready;
    logic [31:0] hwdata;
    logic        hreadyout;
    logic        hresp;
    logic [31:0] hrdata;
    logic [31:0] bram_addra;
    logic [31:0] bram_dina;
    logic [31:0] bram_douta = 32'd0;
    logic        bram_ena;
    logic [3:0]  bram_wea;

    // RAM contents and the bus-order reference copy
    logic [31:0] ram [0:MEM_WORDS-1];
    logic [31:0] ref_mem [0:MEM_WORDS-1];
    logic [31:0] fill_state;
    // fill sequence of the RAM model itself
    logic [31:0] ram_fill;
    logic [31:0] lane_mask;

    // one entry per trace transfer
    logic [7:0]  t_kind [$];
    logic [31:0] t_addr [$];
    logic [2:0]  t_size [$];
    logic [2:0]  t_burst [$];
    logic [31:0] t_wdata [$];
    logic [31:0] t_rdata [$];
    int          t_mode [$];
    logic        t_resp [$];
    int          t_lineno [$];

    int errors;
    int checks;
    int n_lines;
    int cycle_limit;
    int cycle_cnt = 0;
    logic armed = 1'b0;

    ahb_bram_ctrl #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) dut0 (
        .HCLK(HCLK), .HRESETn(HRESETn), .hsel(hsel), .haddr(haddr), .hwrite(hwrite),
        .hsize(hsize), .hburst(hburst), .htrans(htrans), .hready(hready), .hwdata(hwdata),
        .hreadyout(hreadyout), .hresp(hresp), .hrdata(hrdata), .bram_addra(bram_addra),
        .bram_dina(bram_dina), .bram_douta(bram_douta), .bram_ena(bram_ena),
        .bram_wea(bram_wea)
    );

    initial begin
        HCLK = 1'b0;
        forever #10 HCLK = ~HCLK;
    end

    // ======================================================================
    // helpers
    // ======================================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // byte address to RAM row
    function automatic logic [7:0] word_index(input logic [31:0] addr);
        return addr[9:2];
    endfunction

    // AHB lane rules, data sits on the lanes of its address
    function automatic logic [31:0] size_mask(input logic [31:0] addr, input logic [2:0] size);
        case (size)
            3'd0:    return 32'h0000_00ff << {addr[1:0], 3'b000};
            3'd1:    return 32'h0000_ffff << {addr[1], 4'b0000};
            3'd2:    return 32'hffff_ffff;
            default: return 32'h0000_0000;
        endcase
    endfunction

    // read result expected from the reference copy, low bits zero extended
    function automatic logic [31:0] expect_read(input logic [31:0] addr, input logic [2:0] size);
        logic [31:0] w;
        w = ref_mem[word_index(addr)];
        case (size)
            3'd0:    return (w >> {addr[1:0], 3'b000}) & 32'h0000_00ff;
            3'd1:    return (w >> {addr[1], 4'b0000}) & 32'h0000_ffff;
            3'd2:    return w;
            default: return 32'h0000_0000;
        endcase
    endfunction

    task automatic apply_write(input logic [31:0] addr, input logic [2:0] size,
                               input logic [31:0] data);
        logic [31:0] m;
        logic [7:0]  idx;
        m   = size_mask(addr, size);
        idx = word_index(addr);
        ref_mem[idx] = (ref_mem[idx] & ~m) | (data & m);
    endtask

    // RAM model, one cycle read latency, read first on a write
    always @(posedge HCLK) begin
        if (!HRESETn) begin
            ram_fill = SEED;
            for (int i = 0; i < MEM_WORDS; i++) begin
                ram_fill = xorshift32(ram_fill);
                ram[i[7:0]] <= ram_fill;
            end
        end else if (bram_ena) begin
            lane_mask = {{8{bram_wea[3]}}, {8{bram_wea[2]}}, {8{bram_wea[1]}}, {8{bram_wea[0]}}};
            bram_douta <= ram[word_index(bram_addra)];
            ram[word_index(bram_addra)] <= (ram[word_index(bram_addra)] & ~lane_mask) |
                                           (bram_dina & lane_mask);
        end
    end

    // cycle limit from the trace length
    always @(posedge HCLK) begin
        if (armed) begin
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt > cycle_limit) begin
                $display("timeout: run went past %0d cycles", cycle_limit);
                $display("** FAIL **");
                $finish;
            end
        end
    end

    task automatic load_trace();
        int          fd;
        int          code;
        int          lineno;
        string       line;
        logic [7:0]  f_kind;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_rdata;
        int          f_size;
        int          f_burst;
        int          f_mode;
        int          f_resp;
        lineno = 0;
        fd = $fopen("verification/ahb_bram_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file verification/ahb_bram_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                lineno++;
                // skip comments and blank lines
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%c %h %d %d %h %h %d %d", f_kind, f_addr, f_size,
                                   f_burst, f_wdata, f_rdata, f_mode, f_resp);
                    if (code == 8 && (f_kind == "R" || f_kind == "W" || f_kind == "I")) begin
                        t_kind.push_back(f_kind);
                        t_addr.push_back(f_addr);
                        t_size.push_back(f_size[2:0]);
                        t_burst.push_back(f_burst[2:0]);
                        t_wdata.push_back(f_wdata);
                        t_rdata.push_back(f_rdata);
                        t_mode.push_back(f_mode);
                        t_resp.push_back(f_resp[0]);
                        t_lineno.push_back(lineno);
                    end else begin
                        $display("trace line %0d could not be parsed", lineno);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        if (t_kind.size() == 0) begin
            $display("the trace holds no transfers");
            errors++;
        end
    endtask

    task automatic drive_addr_phase(input int idx);
        hsel   = (t_kind[idx] != "I");
        htrans = (t_kind[idx] == "I") ? TRANS_IDLE : TRANS_NONSEQ;
        hwrite = (t_kind[idx] == "W");
        haddr  = t_addr[idx];
        hsize  = hsize_e'(t_size[idx]);
        hburst = t_burst[idx];
    endtask

    task automatic drive_free_cycle();
        hsel   = 1'b0;
        htrans = TRANS_IDLE;
        hwrite = 1'b0;
        haddr  = 32'd0;
        hsize  = SIZE_BYTE;
        hburst = BURST_SINGLE;
    endtask

    // data phase of a trace transfer, mode 0 literal, 1 reference copy, 2 unchecked
    task automatic check_data_phase(input int idx);
        logic [31:0] exp_data;
        checks++;
        if (t_mode[idx] != 2) begin
            exp_data = (t_mode[idx] == 1) ? expect_read(t_addr[idx], t_size[idx])
                                          : t_rdata[idx];
            if (hrdata !== exp_data) begin
                $display("FAIL %0t hrdata: expected %08h, actual %08h (trace line %0d)",
                         $time, exp_data, hrdata, t_lineno[idx]);
                errors++;
            end
        end
        // zero wait state slave
        if (hreadyout !== 1'b1) begin
            $display("FAIL %0t hreadyout: expected 1, actual %0b (trace line %0d)",
                     $time, hreadyout, t_lineno[idx]);
            errors++;
        end
        if (hresp !== t_resp[idx]) begin
            $display("FAIL %0t hresp: expected %0b, actual %0b (trace line %0d)",
                     $time, t_resp[idx], hresp, t_lineno[idx]);
            errors++;
        end
        if (t_kind[idx] == "W") begin
            apply_write(t_addr[idx], t_size[idx], t_wdata[idx]);
        end
    endtask

    // every held write must have landed once the bus is free
    task automatic check_ram();
        for (int i = 0; i < MEM_WORDS; i++) begin
            checks++;
            if (ram[i[7:0]] !== ref_mem[i[7:0]]) begin
                $display("FAIL %0t ram[%02h]: expected %08h, actual %08h",
                         $time, i[7:0], ref_mem[i[7:0]], ram[i[7:0]]);
                errors++;
            end
        end
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================

    initial begin
        HRESETn = 1'b0;
        hready  = 1'b1;
        hwdata  = 32'd0;
        drive_free_cycle();
        errors = 0;
        checks = 0;
        fill_state = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            fill_state = xorshift32(fill_state);
            ref_mem[i[7:0]] = fill_state;
        end
        load_trace();
        n_lines     = t_kind.size();
        cycle_limit = n_lines + MARGIN;

        repeat (2) @(posedge HCLK);
        #1 HRESETn = 1'b1;
        armed = 1'b1;

        // address phase of line i, data phase of line i-1
        for (int i = 0; i <= n_lines; i++) begin
            @(posedge HCLK);
            #1;
            if (i < n_lines) begin
                drive_addr_phase(i);
            end else begin
                drive_free_cycle();
            end
            hwdata = (i > 0 && t_kind[i-1] == "W") ? t_wdata[i-1] : 32'd0;
            #10;
            if (i > 0) begin
                check_data_phase(i - 1);
            end
        end

        repeat (2) @(posedge HCLK);
        #1;
        check_ram();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verification/ahb_bram_assert.sv */
// concurrent checks on the controller top, bound to every ahb_bram_ctrl instance
`timescale 1ns/1ps

module ahb_bram_assert #(
    parameter int DATA_WIDTH = 32
) (
    input logic                    HCLK,
    input logic                    HRESETn,
    input logic                    hreadyout,
    input logic                    bram_ena,
    input logic [DATA_WIDTH/8-1:0] bram_wea,
    input logic                    collide,
    input logic                    buf_active
);

    // zero wait state slave
    a_ready_high: assert property (@(posedge HCLK) disable iff (!HRESETn) hreadyout)
        else $error("hreadyout went low");

    // lanes only with the port enabled
    a_wea_needs_ena: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (bram_wea != '0) |-> bram_ena)
        else $error("bram_wea set while bram_ena is low");

    // buffer fills only from a collision one cycle earlier
    a_buf_after_collide: assert property (@(posedge HCLK) disable iff (!HRESETn)
        $rose(buf_active) |-> $past(collide))
        else $error("write buffer became active without a collision");

endmodule

bind ahb_bram_ctrl ahb_bram_assert #(.DATA_WIDTH(DATA_WIDTH)) u_assert (
    .HCLK(HCLK), .HRESETn(HRESETn), .hreadyout(hreadyout), .bram_ena(bram_ena),
    .bram_wea(bram_wea), .collide(ph_if.collide), .buf_active(wb_if.active)
);

/* verilog/ahb_bram_ctrl.sv */
// top level of the AHB-Lite to single port block RAM slave, zero wait state
`timescale 1ns/1ps

module ahb_bram_ctrl
    import ahb_bram_pkg::*;
#(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                    HCLK,
    input  logic                    HRESETn,
    // AHB-Lite slave side
    input  logic                    hsel,
    input  logic [ADDR_WIDTH-1:0]   haddr,
    input  logic                    hwrite,
    input  hsize_e                  hsize,
    input  logic [2:0]              hburst,
    input  htrans_e                 htrans,
    input  logic                    hready,
    input  logic [DATA_WIDTH-1:0]   hwdata,
    output logic                    hreadyout,
    output logic                    hresp,
    output logic [DATA_WIDTH-1:0]   hrdata,
    // block RAM side, one cycle read latency
    output logic [ADDR_WIDTH-1:0]   bram_addra,
    output logic [DATA_WIDTH-1:0]   bram_dina,
    input  logic [DATA_WIDTH-1:0]   bram_douta,
    output logic                    bram_ena,
    output logic [DATA_WIDTH/8-1:0] bram_wea
);

    logic [ADDR_WIDTH-1:0]   lat_addr;
    logic [DATA_WIDTH/8-1:0] lat_wea;
    hsize_e                  lat_size;

    phase_if ph_if ();
    wbuf_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) wb_if ();

    // never stalls the bus
    assign hreadyout = 1'b1;

    ahb_bram_phase_fsm u_fsm (
        .HCLK(HCLK), .HRESETn(HRESETn), .hsel(hsel), .hready(hready),
        .htrans(htrans), .hwrite(hwrite), .ph(ph_if.fsm)
    );

    ahb_bram_resp_gen u_resp (
        .HCLK(HCLK), .HRESETn(HRESETn), .ph(ph_if.resp), .hsize(hsize),
        .hburst(hburst), .addr_lo(haddr[1:0]), .hresp(hresp)
    );

    ahb_bram_write_buffer #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) u_wbuf (
        .HCLK(HCLK), .HRESETn(HRESETn), .ph(ph_if.wbuf), .wr_addr(lat_addr),
        .wr_data(hwdata), .wr_wea(lat_wea), .wb(wb_if.owner)
    );

    ahb_bram_port_mux #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) u_mux (
        .HCLK(HCLK), .HRESETn(HRESETn), .ph(ph_if.mux), .haddr(haddr), .hsize(hsize),
        .hwdata(hwdata), .wb(wb_if.user), .lat_addr(lat_addr), .lat_wea(lat_wea),
        .lat_size(lat_size), .bram_addra(bram_addra), .bram_dina(bram_dina),
        .bram_ena(bram_ena), .bram_wea(bram_wea)
    );

    ahb_bram_rdata_align #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) u_align (
        .HCLK(HCLK), .HRESETn(HRESETn), .ph(ph_if.align), .bram_addra(bram_addra),
        .lat_size(lat_size), .bram_douta(bram_douta), .wb(wb_if.user), .hrdata(hrdata)
    );

endmodule

/* verilog/ahb_bram_rdata_align.sv */
// builds HRDATA from the RAM word, merging held write bytes and aligning to the transfer size
`timescale 1ns/1ps

module ahb_bram_rdata_align
    import ahb_bram_pkg::*;
#(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  HCLK,
    input  logic                  HRESETn,
    phase_if.align                ph,
    input  logic [ADDR_WIDTH-1:0] bram_addra,
    input  hsize_e                lat_size,
    input  logic [DATA_WIDTH-1:0] bram_douta,
    wbuf_if.user                  wb,
    output logic [DATA_WIDTH-1:0] hrdata
);

    localparam int NBYTES = DATA_WIDTH / 8;
    localparam int OFF_W  = $clog2(NBYTES);

    logic [ADDR_WIDTH-1:0] addr_d1;
    logic                  hit;
    logic [DATA_WIDTH-1:0] merged;
    logic [OFF_W-1:0]      off;

    // RAM address of the cycle whose data is on bram_douta now
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            addr_d1 <= '0;
        end else begin
            addr_d1 <= bram_addra;
        end
    end

    // held write to the same RAM row overrides its enabled lanes
    assign hit = wb.active && (addr_d1[ADDR_WIDTH-1:OFF_W] == wb.addr[ADDR_WIDTH-1:OFF_W]);
    assign off = addr_d1[OFF_W-1:0];

    always_comb begin
        for (int i = 0; i < NBYTES; i++) begin
            merged[8*i +: 8] = (hit && wb.wea[i]) ? wb.data[8*i +: 8] : bram_douta[8*i +: 8];
        end
    end

    // zero extended into the low bits, only in a read data phase
    always_comb begin
        hrdata = '0;
        if (ph.rd_pend) begin
            case (lat_size)
                SIZE_BYTE: hrdata = DATA_WIDTH'(merged[8*off +: 8]);
                SIZE_HALF: hrdata = DATA_WIDTH'(merged[8*(off & ~OFF_W'(1)) +: 16]);
                SIZE_WORD: hrdata = DATA_WIDTH'(merged[8*(off & ~OFF_W'(3)) +: 32]);
                default:   hrdata = '0;
            endcase
        end
    end

endmodule

/* verilog/ahb_bram_port_mux.sv */
// latches the AHB address phase, decodes byte lanes and arbitrates the single RAM port
`timescale 1ns/1ps

module ahb_bram_port_mux
    import ahb_bram_pkg::*;
#(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                    HCLK,
    input  logic                    HRESETn,
    phase_if.mux                    ph,
    input  logic [ADDR_WIDTH-1:0]   haddr,
    input  hsize_e                  hsize,
    input  logic [DATA_WIDTH-1:0]   hwdata,
    wbuf_if.user                    wb,
    output logic [ADDR_WIDTH-1:0]   lat_addr,
    output logic [DATA_WIDTH/8-1:0] lat_wea,
    output hsize_e                  lat_size,
    output logic [ADDR_WIDTH-1:0]   bram_addra,
    output logic [DATA_WIDTH-1:0]   bram_dina,
    output logic                    bram_ena,
    output logic [DATA_WIDTH/8-1:0] bram_wea
);

    localparam int NBYTES = DATA_WIDTH / 8;
    localparam int OFF_W  = $clog2(NBYTES);

    logic              addr_ph;
    logic              flush;
    logic [OFF_W-1:0]  off;
    logic [NBYTES-1:0] be_dec;

    assign addr_ph = (ph.phase == PH_WRITE) || (ph.phase == PH_READ);
    // held write goes out when the port is free
    assign flush   = wb.active && ph.release_cyc;
    assign off     = haddr[OFF_W-1:0];

    // ======================================================================
    // address phase capture
    // ======================================================================

    // lanes are aligned down to the transfer size
    always_comb begin
        case (hsize)
            SIZE_BYTE: be_dec = NBYTES'(1) << off;
            SIZE_HALF: be_dec = NBYTES'(2'b11) << (off & ~OFF_W'(1));
            SIZE_WORD: be_dec = NBYTES'(4'hf) << (off & ~OFF_W'(3));
            default:   be_dec = '0;
        endcase
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            lat_size <= SIZE_BYTE;
            lat_wea  <= '0;
        end else begin
            if (addr_ph) begin
                lat_size <= hsize;
            end
            // enables live for exactly one write data phase
            lat_wea <= (ph.phase == PH_WRITE) ? be_dec : {NBYTES{1'b0}};
        end
    end

    always_ff @(posedge HCLK) begin
        if (addr_ph) begin
            lat_addr <= haddr;
        end
    end

    // ======================================================================
    // RAM port
    // ======================================================================

    // address and enable: live read first, then data phase write, then buffer
    always_comb begin
        bram_ena   = 1'b0;
        bram_addra = '0;
        if (ph.rd_now) begin
            bram_ena   = 1'b1;
            bram_addra = haddr;
        end else if (ph.wr_pend) begin
            bram_ena   = 1'b1;
            bram_addra = lat_addr;
        end else if (flush) begin
            bram_ena   = 1'b1;
            bram_addra = wb.addr;
        end
    end

    // data and lanes, a colliding write is parked so its lanes stay off
    always_comb begin
        bram_dina = '0;
        bram_wea  = '0;
        if (ph.wr_pend) begin
            bram_dina = hwdata;
            bram_wea  = ph.collide ? {NBYTES{1'b0}} : lat_wea;
        end else if (flush) begin
            bram_dina = wb.data;
            bram_wea  = wb.wea;
        end
    end

endmodule

/* verilog/ahb_bram_write_buffer.sv */
// holds a write that lost the RAM port to a read until the next release cycle
`timescale 1ns/1ps

module ahb_bram_write_buffer #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                    HCLK,
    input  logic                    HRESETn,
    phase_if.wbuf                   ph,
    input  logic [ADDR_WIDTH-1:0]   wr_addr,
    input  logic [DATA_WIDTH-1:0]   wr_data,
    input  logic [DATA_WIDTH/8-1:0] wr_wea,
    wbuf_if.owner                   wb
);

    localparam int NBYTES = DATA_WIDTH / 8;

    // valid flag and lane enables
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            wb.active <= 1'b0;
            wb.wea    <= '0;
        end else if (ph.collide) begin
            // a second collision overwrites, resp_gen flags that case
            wb.active <= 1'b1;
            wb.wea    <= wr_wea;
        end else if (ph.release_cyc) begin
            wb.active <= 1'b0;
            wb.wea    <= {NBYTES{1'b0}};
        end
    end

    // held address and write data
    always_ff @(posedge HCLK) begin
        if (ph.collide) begin
            wb.addr <= wr_addr;
            wb.data <= wr_data;
        end else if (ph.release_cyc) begin
            wb.addr <= '0;
            wb.data <= '0;
        end
    end

endmodule

/* verilog/ahb_bram_resp_gen.sv */
// registers the AHB error response from transfer attributes and write buffer overflow
`timescale 1ns/1ps

module ahb_bram_resp_gen
    import ahb_bram_pkg::*;
(
    input  logic       HCLK,
    input  logic       HRESETn,
    phase_if.resp      ph,
    input  hsize_e     hsize,
    input  logic [2:0] hburst,
    input  logic [1:0] addr_lo,
    output logic       hresp
);

    logic [1:0] ovf_cnt;
    logic       addr_ph;
    logic       size_err;
    logic       burst_err;
    logic       align_err;
    logic       ovf_err;

    // collisions not yet drained by a release cycle, saturates at the limit
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            ovf_cnt <= 2'd0;
        end else if (ph.collide) begin
            if (ovf_cnt != OVF_LIMIT) begin
                ovf_cnt <= ovf_cnt + 2'd1;
            end
        end else if (ph.release_cyc) begin
            ovf_cnt <= 2'd0;
        end
    end

    assign addr_ph   = (ph.phase == PH_WRITE) || (ph.phase == PH_READ);
    assign size_err  = (hsize > SIZE_WORD);
    assign burst_err = (hburst != BURST_SINGLE);
    // halfword needs bit 0 clear, word needs both low bits clear
    assign align_err = ((hsize == SIZE_HALF) && addr_lo[0]) ||
                       ((hsize == SIZE_WORD) && (addr_lo != 2'b00));
    assign ovf_err   = (ovf_cnt == OVF_LIMIT);

    // one cycle of ERROR in the data phase of a bad address phase
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            hresp <= HRESP_OKAY;
        end else if (addr_ph && (size_err || burst_err || align_err || ovf_err)) begin
            hresp <= HRESP_ERROR;
        end else begin
            hresp <= HRESP_OKAY;
        end
    end

endmodule

/* verilog/ahb_bram_phase_fsm.sv */
// classifies each AHB cycle and derives the collision and release strobes for the controller
`timescale 1ns/1ps

module ahb_bram_phase_fsm
    import ahb_bram_pkg::*;
(
    input  logic    HCLK,
    input  logic    HRESETn,
    input  logic    hsel,
    input  logic    hready,
    input  htrans_e htrans,
    input  logic    hwrite,
    phase_if.fsm    ph
);

    bus_phase_e cur_phase;
    bus_phase_e prev_phase;
    logic       sel_xfer;

    // ======================================================================
    // current phase decode
    // ======================================================================

    // SEQ and BUSY are not served, they count as free cycles
    assign sel_xfer = hsel && hready && (htrans == TRANS_NONSEQ);

    always_comb begin
        if (!sel_xfer) begin
            cur_phase = PH_FREE;
        end else if (hwrite) begin
            cur_phase = PH_WRITE;
        end else begin
            cur_phase = PH_READ;
        end
    end

    // previous phase, IDLE out of reset so no pend flag fires
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            prev_phase <= PH_IDLE;
        end else begin
            prev_phase <= cur_phase;
        end
    end

    // ======================================================================
    // strobes
    // ======================================================================

    assign ph.phase   = cur_phase;
    assign ph.rd_now  = (cur_phase == PH_READ);
    assign ph.wr_pend = (prev_phase == PH_WRITE);
    assign ph.rd_pend = (prev_phase == PH_READ);

    // write data arrives while the RAM is needed for a read address
    assign ph.collide = (prev_phase == PH_WRITE) && (cur_phase == PH_READ);

    // RAM port unused by the live transfer: a free cycle, or a write
    // address phase behind a read, whose data comes only next cycle
    assign ph.release_cyc = (cur_phase == PH_FREE) ||
                            ((prev_phase == PH_READ) && (cur_phase == PH_WRITE));

endmodule

/* verilog/ahb_bram_ifs.sv */
// bus phase and write buffer interfaces shared between the controller submodules
`timescale 1ns/1ps

// phase decode results, driven by the phase FSM
interface phase_if import ahb_bram_pkg::*; ();
    // read address phase this cycle
    logic       rd_now;
    // previous cycle was a write or read address phase
    logic       wr_pend;
    logic       rd_pend;
    // write data phase overlaps a read address phase
    logic       collide;
    // RAM port is free for the held write this cycle
    logic       release_cyc;
    bus_phase_e phase;

    modport fsm   (output rd_now, wr_pend, rd_pend, collide, release_cyc, phase);
    modport mux   (input rd_now, wr_pend, collide, release_cyc, phase);
    modport wbuf  (input collide, release_cyc);
    modport align (input rd_pend);
    modport resp  (input collide, release_cyc, phase);
endinterface

// held write, driven by the write buffer
interface wbuf_if #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) ();
    logic                    active;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   data;
    logic [DATA_WIDTH/8-1:0] wea;

    modport owner (output active, addr, data, wea);
    modport user  (input active, addr, data, wea);
endinterface

/* verilog/ahb_bram_pkg.sv */
// shared bus codes, phase kinds and limits, imported by every module of the AHB to BRAM slave
package ahb_bram_pkg;

    // ======================================================================
    // AHB-Lite encodings
    // ======================================================================

    // HTRANS, only NONSEQ starts a transfer here
    typedef enum logic [1:0] {
        TRANS_IDLE   = 2'b00,
        TRANS_BUSY   = 2'b01,
        TRANS_NONSEQ = 2'b10,
        TRANS_SEQ    = 2'b11
    } htrans_e;

    // HSIZE, anything above word is flagged as an error
    typedef enum logic [2:0] {
        SIZE_BYTE   = 3'd0,
        SIZE_HALF   = 3'd1,
        SIZE_WORD   = 3'd2,
        SIZE_DWORD  = 3'd3,
        SIZE_4WORD  = 3'd4,
        SIZE_8WORD  = 3'd5,
        SIZE_16WORD = 3'd6,
        SIZE_32WORD = 3'd7
    } hsize_e;

    // the only HBURST code accepted
    localparam logic [2:0] BURST_SINGLE = 3'b000;

    // HRESP codes
    localparam logic HRESP_OKAY  = 1'b0;
    localparam logic HRESP_ERROR = 1'b1;

    // ======================================================================
    // controller internals
    // ======================================================================

    // kind of address phase seen in a cycle, IDLE only out of reset
    typedef enum logic [1:0] {
        PH_FREE  = 2'b00,
        PH_WRITE = 2'b01,
        PH_READ  = 2'b10,
        PH_IDLE  = 2'b11
    } bus_phase_e;

    // undrained collision count at which the write buffer would be overwritten
    localparam logic [1:0] OVF_LIMIT = 2'd2;

endpackage
